//--- hdl/CpuPkg.sv
`default_nettype none

package CpuPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and instruction fields
    //////////////////////////////////////////////////////////////////////
    localparam int DATA_W   = 16;                    // Instruction and address width
    localparam int OPCODE_W = 4;                     // Opcode in instr[15:12]
    localparam int CC_W     = 3;                     // Condition code in instr[11:9]
    localparam int IMM_W    = 9;                     // Branch offset in instr[8:0], in halfwords

    localparam logic [DATA_W-1:0] RESET_PC = '0;     // First fetch address
    localparam logic [DATA_W-1:0] PC_STEP  = 16'd2;  // Byte addressed, 2-byte instructions

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////
    localparam logic [OPCODE_W-1:0] OP_ADD    = 4'd0;
    localparam logic [OPCODE_W-1:0] OP_SUB    = 4'd1;
    localparam logic [OPCODE_W-1:0] OP_XOR    = 4'd2;
    localparam logic [OPCODE_W-1:0] OP_RED    = 4'd3;   // Reduction add
    localparam logic [OPCODE_W-1:0] OP_SLL    = 4'd4;
    localparam logic [OPCODE_W-1:0] OP_SRA    = 4'd5;
    localparam logic [OPCODE_W-1:0] OP_ROR    = 4'd6;
    localparam logic [OPCODE_W-1:0] OP_PADDSB = 4'd7;   // Parallel saturating byte add
    localparam logic [OPCODE_W-1:0] OP_LW     = 4'd8;
    localparam logic [OPCODE_W-1:0] OP_SW     = 4'd9;
    localparam logic [OPCODE_W-1:0] OP_LLB    = 4'd10;
    localparam logic [OPCODE_W-1:0] OP_LHB    = 4'd11;
    localparam logic [OPCODE_W-1:0] OP_B      = 4'd12;  // PC relative branch
    localparam logic [OPCODE_W-1:0] OP_BR     = 4'd13;  // Register branch
    localparam logic [OPCODE_W-1:0] OP_PCS    = 4'd14;
    localparam logic [OPCODE_W-1:0] OP_HLT    = 4'd15;

    //////////////////////////////////////////////////////////////////////
    // Branch condition codes
    //////////////////////////////////////////////////////////////////////
    localparam logic [CC_W-1:0] CC_NE     = 3'd0;       // Z == 0
    localparam logic [CC_W-1:0] CC_EQ     = 3'd1;       // Z == 1
    localparam logic [CC_W-1:0] CC_GT     = 3'd2;       // Z == 0 and N == 0
    localparam logic [CC_W-1:0] CC_LT     = 3'd3;       // N == 1
    localparam logic [CC_W-1:0] CC_GE     = 3'd4;       // Z == 1 or N == 0
    localparam logic [CC_W-1:0] CC_LE     = 3'd5;       // Z == 1 or N == 1
    localparam logic [CC_W-1:0] CC_OV     = 3'd6;       // V == 1
    localparam logic [CC_W-1:0] CC_UNCOND = 3'd7;

    //////////////////////////////////////////////////////////////////////
    // Predictor geometry
    //////////////////////////////////////////////////////////////////////
    localparam int PRED_ENTRIES = 8;                 // Direct mapped on PC[3:1]
    localparam int PRED_IDX_W   = 3;
    localparam int CTR_W        = 2;                 // Saturating counter, MSB is the guess

    localparam logic [CTR_W-1:0] CTR_RESET = 2'd1;   // Weakly not taken

endpackage

`default_nettype wire

//--- hdl/PredictTable.sv
`timescale 1ns/10ps
`default_nettype none

module PredictTable #(
    parameter type   entryT     = logic [CpuPkg::DATA_W-1:0],
    parameter entryT resetValue = '0
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [CpuPkg::PRED_IDX_W-1:0] rdIdx,
    input  logic                          wrEn,
    input  logic [CpuPkg::PRED_IDX_W-1:0] wrIdx,
    input  entryT                         wrData,
    output entryT                         rdData
);

    entryT entries [CpuPkg::PRED_ENTRIES];

    assign rdData = entries[rdIdx];               // Same cycle write is not seen here

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < CpuPkg::PRED_ENTRIES; i++) begin
                entries[i] <= resetValue;         // Table starts from a known guess
            end
        end else if (wrEn) begin
            entries[wrIdx] <= wrData;
        end
    end

endmodule

`default_nettype wire

//--- hdl/BranchPredictor.sv
`timescale 1ns/10ps
`default_nettype none

module BranchPredictor (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [CpuPkg::DATA_W-1:0] fetchPc,      // Lookup address
    input  logic [CpuPkg::DATA_W-1:0] updPc,        // Address of the branch in decode
    input  logic                      wenBht,
    input  logic                      wenBtb,
    input  logic                      actualTaken,
    input  logic [CpuPkg::DATA_W-1:0] actualNext,
    output logic                      predTaken,
    output logic [CpuPkg::DATA_W-1:0] predTarget
);

    logic [CpuPkg::PRED_IDX_W-1:0] fetchIdx;
    logic [CpuPkg::PRED_IDX_W-1:0] updIdx;
    logic [CpuPkg::CTR_W-1:0]      ctrRd;          // Counter at fetch
    logic [CpuPkg::CTR_W-1:0]      ctrDec;         // Counter of the branch in decode
    logic [CpuPkg::CTR_W-1:0]      ctrNext;        // Writeback value

    assign fetchIdx = fetchPc[CpuPkg::PRED_IDX_W:1];
    assign updIdx   = updPc[CpuPkg::PRED_IDX_W:1];

    PredictTable #(
        .entryT     (logic [CpuPkg::CTR_W-1:0]),
        .resetValue (CpuPkg::CTR_RESET)
    ) bht_i (
        .clk    (clk),
        .rstN   (rstN),
        .rdIdx  (fetchIdx),
        .wrEn   (wenBht),
        .wrIdx  (updIdx),
        .wrData (ctrNext),
        .rdData (ctrRd)
    );

    PredictTable #(
        .entryT     (logic [CpuPkg::DATA_W-1:0]),
        .resetValue ('0)
    ) btb_i (
        .clk    (clk),
        .rstN   (rstN),
        .rdIdx  (fetchIdx),
        .wrEn   (wenBtb),
        .wrIdx  (updIdx),
        .wrData (actualNext),
        .rdData (predTarget)
    );

    assign predTaken = ctrRd[CpuPkg::CTR_W-1];    // Upper half of the range means taken

    // Table has one read port, so the counter rides along with the fetch
    always_ff @(posedge clk) begin
        if (wenBht && (updIdx == fetchIdx)) begin
            ctrDec <= ctrNext;                    // Forward the write landing this edge
        end else begin
            ctrDec <= ctrRd;
        end
    end

    always_comb begin
        ctrNext = ctrDec;                         // Hold at either end
        if (actualTaken) begin
            if (ctrDec != '1) ctrNext = ctrDec + CpuPkg::CTR_W'(1);
        end else begin
            if (ctrDec != '0) ctrNext = ctrDec - CpuPkg::CTR_W'(1);
        end
    end

endmodule

`default_nettype wire

//--- hdl/FetchUnit.sv
`timescale 1ns/10ps
`default_nettype none

module FetchUnit (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      halt,         // Freeze on HLT
    input  logic                      updatePc,     // Decode found a wrong path
    input  logic [CpuPkg::DATA_W-1:0] redirectPc,
    input  logic                      predTaken,
    input  logic [CpuPkg::DATA_W-1:0] predTarget,
    output logic [CpuPkg::DATA_W-1:0] pc,           // Instruction memory address
    output logic [CpuPkg::DATA_W-1:0] predNext      // Guessed successor of pc
);

    //////////////////////////////////////////////////////////////////////
    // Next fetch address
    //////////////////////////////////////////////////////////////////////
    assign predNext = predTaken ? predTarget : pc + CpuPkg::PC_STEP;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= CpuPkg::RESET_PC;
        end else if (updatePc) begin
            pc <= redirectPc;                     // Correction wins over everything
        end else if (!halt) begin
            pc <= predNext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/IfIdReg.sv
`timescale 1ns/10ps
`default_nettype none

module IfIdReg (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      flush,        // Drop the wrong path fetch
    input  logic                      hold,         // Keep the current entry
    input  logic [CpuPkg::DATA_W-1:0] instrIn,
    input  logic [CpuPkg::DATA_W-1:0] pcIn,
    input  logic                      predTakenIn,
    input  logic [CpuPkg::DATA_W-1:0] predNextIn,
    output logic [CpuPkg::DATA_W-1:0] instrOut,
    output logic [CpuPkg::DATA_W-1:0] pcOut,
    output logic                      predTakenOut,
    output logic [CpuPkg::DATA_W-1:0] predNextOut,
    output logic                      valid
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;                        // Bubble after a redirect
        end else if (!hold) begin
            valid <= 1'b1;
        end
    end

    // Fields are only meaningful while valid is set
    always_ff @(posedge clk) begin
        if (flush || !hold) begin
            instrOut     <= instrIn;
            pcOut        <= pcIn;
            predTakenOut <= predTakenIn;
            predNextOut  <= predNextIn;
        end
    end

endmodule

`default_nettype wire

//--- hdl/BranchResolver.sv
`timescale 1ns/10ps
`default_nettype none

module BranchResolver (
    input  logic [CpuPkg::DATA_W-1:0] instr,        // Instruction in decode
    input  logic [CpuPkg::DATA_W-1:0] pc,           // Its address
    input  logic                      zFlag,
    input  logic                      nFlag,
    input  logic                      vFlag,
    input  logic [CpuPkg::DATA_W-1:0] brReg,        // Register target for BR
    output logic                      actualTaken,
    output logic [CpuPkg::DATA_W-1:0] actualNext
);

    logic [CpuPkg::OPCODE_W-1:0] opcode;
    logic [CpuPkg::CC_W-1:0]     cc;
    logic [CpuPkg::IMM_W-1:0]    imm;
    logic                        isBranch;
    logic                        condMet;
    logic [CpuPkg::DATA_W-1:0]   pcPlus2;
    logic [CpuPkg::DATA_W-1:0]   immOffset;        // Byte offset from halfword imm
    logic [CpuPkg::DATA_W-1:0]   takenTarget;

    assign opcode   = instr[CpuPkg::DATA_W-1 -: CpuPkg::OPCODE_W];
    assign cc       = instr[CpuPkg::IMM_W +: CpuPkg::CC_W];
    assign imm      = instr[CpuPkg::IMM_W-1:0];
    assign isBranch = (opcode == CpuPkg::OP_B) || (opcode == CpuPkg::OP_BR);

    always_comb begin
        case (cc)
            CpuPkg::CC_NE:     condMet = !zFlag;
            CpuPkg::CC_EQ:     condMet = zFlag;
            CpuPkg::CC_GT:     condMet = !zFlag && !nFlag;
            CpuPkg::CC_LT:     condMet = nFlag;
            CpuPkg::CC_GE:     condMet = zFlag || !nFlag;
            CpuPkg::CC_LE:     condMet = zFlag || nFlag;
            CpuPkg::CC_OV:     condMet = vFlag;
            CpuPkg::CC_UNCOND: condMet = 1'b1;
        endcase
    end

    assign pcPlus2   = pc + CpuPkg::PC_STEP;
    assign immOffset = {{(CpuPkg::DATA_W-CpuPkg::IMM_W-1){imm[CpuPkg::IMM_W-1]}}, imm, 1'b0};
    // B is relative to the next instruction, BR jumps to the register
    assign takenTarget = (opcode == CpuPkg::OP_BR) ? brReg : pcPlus2 + immOffset;

    assign actualTaken = isBranch && condMet;      // Non-branches never redirect
    assign actualNext  = actualTaken ? takenTarget : pcPlus2;

endmodule

`default_nettype wire

//--- hdl/ControlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module ControlUnit (
    input  logic                        valid,        // Decode slot holds a live instruction
    input  logic [CpuPkg::OPCODE_W-1:0] opcode,
    input  logic                        actualTaken,  // Resolved direction
    input  logic                        predTaken,    // Direction guessed at fetch
    input  logic [CpuPkg::DATA_W-1:0]   predNext,     // Address fetched after this one
    input  logic [CpuPkg::DATA_W-1:0]   actualNext,   // Address that should follow

    output logic                        branch,
    output logic                        wenBtb,       // Train target buffer
    output logic                        wenBht,       // Train history counter
    output logic                        updatePc,     // Redirect fetch and flush IF/ID

    output logic [CpuPkg::OPCODE_W-1:0] aluOp,
    output logic                        aluSrc,       // Immediate operand
    output logic                        regSrc,       // Read port 1 takes rd
    output logic                        zEn,
    output logic                        nvEn,

    output logic                        memEnable,
    output logic                        memWrite,

    output logic                        regWrite,
    output logic                        memToReg,
    output logic                        hlt,
    output logic                        pcs
);

    logic mispredicted;                               // Direction guess was wrong
    logic nextMiss;                                   // Wrong path is in fetch
    logic targetMiss;                                 // Taken as guessed, stale BTB target

    assign mispredicted = predTaken ^ actualTaken;
    assign nextMiss     = predNext != actualNext;
    assign targetMiss   = predTaken && actualTaken && nextMiss;

    //////////////////////////////////////////////////////////////////////
    // Opcode decode, all zero on a bubble
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        branch    = 1'b0;
        wenBtb    = 1'b0;
        wenBht    = 1'b0;
        updatePc  = 1'b0;
        aluOp     = '0;
        aluSrc    = 1'b0;
        regSrc    = 1'b0;
        zEn       = 1'b0;
        nvEn      = 1'b0;
        memEnable = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        memToReg  = 1'b0;
        hlt       = 1'b0;
        pcs       = 1'b0;

        if (valid) begin
            aluOp    = opcode;                        // ALU sees the raw opcode
            regWrite = 1'b1;                          // Most opcodes write back
            case (opcode)
                CpuPkg::OP_ADD, CpuPkg::OP_SUB: begin
                    zEn  = 1'b1;
                    nvEn = 1'b1;                      // Arithmetic sets all flags
                end
                CpuPkg::OP_XOR: begin
                    zEn = 1'b1;
                end
                CpuPkg::OP_SLL, CpuPkg::OP_SRA, CpuPkg::OP_ROR: begin
                    aluSrc = 1'b1;                    // Shift amount from imm
                    zEn    = 1'b1;
                end
                CpuPkg::OP_RED, CpuPkg::OP_PADDSB: begin
                    // Byte arithmetic leaves the flags alone
                end
                CpuPkg::OP_LW: begin
                    aluSrc    = 1'b1;                 // Base plus offset
                    memToReg  = 1'b1;
                    memEnable = 1'b1;
                end
                CpuPkg::OP_SW: begin
                    aluSrc    = 1'b1;
                    regWrite  = 1'b0;
                    memEnable = 1'b1;
                    memToReg  = 1'b1;                 // Unused, no writeback
                    memWrite  = 1'b1;
                end
                CpuPkg::OP_LLB, CpuPkg::OP_LHB: begin
                    aluSrc = 1'b1;
                    regSrc = 1'b1;                    // rd is also a source
                end
                CpuPkg::OP_B, CpuPkg::OP_BR: begin
                    branch = 1'b1;
                    wenBht = 1'b1;                    // Every resolved branch trains
                    // Direction miss only costs a redirect when the two paths differ
                    updatePc = (mispredicted && nextMiss) || targetMiss;
                    wenBtb   = (mispredicted && actualTaken && nextMiss) || targetMiss;
                end
                CpuPkg::OP_PCS: begin
                    pcs = 1'b1;
                end
                CpuPkg::OP_HLT: begin
                    hlt      = 1'b1;
                    regWrite = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/FrontEnd.sv
`timescale 1ns/10ps
`default_nettype none

module FrontEnd (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [CpuPkg::DATA_W-1:0]   instr,        // Combinational memory read data
    input  logic                        zFlag,
    input  logic                        nFlag,
    input  logic                        vFlag,
    input  logic [CpuPkg::DATA_W-1:0]   brReg,

    output logic [CpuPkg::DATA_W-1:0]   imemAddr,
    output logic [CpuPkg::DATA_W-1:0]   idPc,
    output logic                        idValid,
    output logic                        branch,
    output logic                        wenBtb,
    output logic                        wenBht,
    output logic                        updatePc,
    output logic [CpuPkg::OPCODE_W-1:0] aluOp,
    output logic                        aluSrc,
    output logic                        regSrc,
    output logic                        zEn,
    output logic                        nvEn,
    output logic                        memEnable,
    output logic                        memWrite,
    output logic                        regWrite,
    output logic                        memToReg,
    output logic                        hlt,
    output logic                        pcs
);

    logic                      predTaken;
    logic [CpuPkg::DATA_W-1:0] predTarget;
    logic [CpuPkg::DATA_W-1:0] predNext;
    logic [CpuPkg::DATA_W-1:0] idInstr;
    logic                      idPredTaken;
    logic [CpuPkg::DATA_W-1:0] idPredNext;
    logic                      actualTaken;
    logic [CpuPkg::DATA_W-1:0] actualNext;

    //////////////////////////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////////////////////////
    FetchUnit FetchUnit_i (
        .clk        (clk),
        .rstN       (rstN),
        .halt       (hlt),
        .updatePc   (updatePc),
        .redirectPc (actualNext),
        .predTaken  (predTaken),
        .predTarget (predTarget),
        .pc         (imemAddr),
        .predNext   (predNext)
    );

    BranchPredictor BranchPredictor_i (
        .clk         (clk),
        .rstN        (rstN),
        .fetchPc     (imemAddr),
        .updPc       (idPc),                      // Trained from decode
        .wenBht      (wenBht),
        .wenBtb      (wenBtb),
        .actualTaken (actualTaken),
        .actualNext  (actualNext),
        .predTaken   (predTaken),
        .predTarget  (predTarget)
    );

    IfIdReg IfIdReg_i (
        .clk          (clk),
        .rstN         (rstN),
        .flush        (updatePc),
        .hold         (hlt),
        .instrIn      (instr),
        .pcIn         (imemAddr),
        .predTakenIn  (predTaken),
        .predNextIn   (predNext),
        .instrOut     (idInstr),
        .pcOut        (idPc),
        .predTakenOut (idPredTaken),
        .predNextOut  (idPredNext),
        .valid        (idValid)
    );

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////
    BranchResolver BranchResolver_i (
        .instr       (idInstr),
        .pc          (idPc),
        .zFlag       (zFlag),
        .nFlag       (nFlag),
        .vFlag       (vFlag),
        .brReg       (brReg),
        .actualTaken (actualTaken),
        .actualNext  (actualNext)
    );

    ControlUnit ControlUnit_i (
        .valid       (idValid),
        .opcode      (idInstr[CpuPkg::DATA_W-1 -: CpuPkg::OPCODE_W]),
        .actualTaken (actualTaken),
        .predTaken   (idPredTaken),
        .predNext    (idPredNext),
        .actualNext  (actualNext),
        .branch      (branch),
        .wenBtb      (wenBtb),
        .wenBht      (wenBht),
        .updatePc    (updatePc),
        .aluOp       (aluOp),
        .aluSrc      (aluSrc),
        .regSrc      (regSrc),
        .zEn         (zEn),
        .nvEn        (nvEn),
        .memEnable   (memEnable),
        .memWrite    (memWrite),
        .regWrite    (regWrite),
        .memToReg    (memToReg),
        .hlt         (hlt),
        .pcs         (pcs)
    );

endmodule

`default_nettype wire

//--- test/FrontEnd_checker.sv
`timescale 1ns/10ps
`default_nettype none

module FrontEnd_checker (
    input logic        clk,
    input logic        rstN,
    input logic [15:0] imemAddr,
    input logic        idValid,
    input logic        updatePc,
    input logic        hlt,
    input logic        memEnable,
    input logic        memWrite,
    input logic        regWrite,
    input logic        wenBht,
    input logic        wenBtb
);

    // Redirect always leaves one bubble
    redirectFlush: assert property (@(posedge clk) disable iff (!rstN)
        updatePc |=> !idValid) else $error("updatePc not followed by a bubble");

    // Fetch freezes on halt
    haltHold: assert property (@(posedge clk) disable iff (!rstN)
        hlt |=> imemAddr == $past(imemAddr)) else $error("imemAddr moved during halt");

    storeEnable: assert property (@(posedge clk) disable iff (!rstN)
        memWrite |-> memEnable) else $error("memWrite without memEnable");

    bubbleQuiet: assert property (@(posedge clk)
        !idValid |-> !(regWrite || memEnable || memWrite || wenBht || wenBtb || updatePc || hlt))
        else $error("Enable active on a bubble");

endmodule

bind FrontEnd FrontEnd_checker FrontEnd_checker_i (
    .clk(clk), .rstN(rstN), .imemAddr(imemAddr), .idValid(idValid), .updatePc(updatePc),
    .hlt(hlt), .memEnable(memEnable), .memWrite(memWrite), .regWrite(regWrite),
    .wenBht(wenBht), .wenBtb(wenBtb)
);

`default_nettype wire

//--- test/FrontEndTb.sv
`timescale 1ns/10ps
`default_nettype none

module FrontEndTb;

    logic        clk;
    logic        rstN;
    logic [15:0] instr;
    logic        zFlag;
    logic        nFlag;
    logic        vFlag;
    logic [15:0] brReg;
    logic [15:0] imemAddr;
    logic [15:0] idPc;
    logic        idValid;
    logic        branch, wenBtb, wenBht, updatePc;
    logic [3:0]  aluOp;
    logic        aluSrc, regSrc, zEn, nvEn, memEnable, memWrite;
    logic        regWrite, memToReg, hlt, pcs;

    logic [15:0] imem [64];                        // Word addressed instruction memory
    integer      seed;
    integer      errors;                           // All checks
    integer      testErrors;                       // Checks of the running test
    integer      redirects;
    integer      brDecodes;
    logic        timedOut;

    // Reference model state
    logic [15:0] mPc;
    logic        mIdValid;
    logic [15:0] mIdInstr, mIdPc, mIdPredNext;
    logic [1:0]  mBht [8];
    logic [15:0] mBtb [8];
    logic        redirectDue;
    logic [15:0] redirectAddr;

    FrontEnd FrontEnd_i (
        .clk(clk), .rstN(rstN), .instr(instr), .zFlag(zFlag), .nFlag(nFlag),
        .vFlag(vFlag), .brReg(brReg), .imemAddr(imemAddr), .idPc(idPc),
        .idValid(idValid), .branch(branch), .wenBtb(wenBtb), .wenBht(wenBht),
        .updatePc(updatePc), .aluOp(aluOp), .aluSrc(aluSrc), .regSrc(regSrc),
        .zEn(zEn), .nvEn(nvEn), .memEnable(memEnable), .memWrite(memWrite),
        .regWrite(regWrite), .memToReg(memToReg), .hlt(hlt), .pcs(pcs)
    );

    assign instr = imem[imemAddr[6:1]];            // Combinational fetch

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Model helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic condHolds(input logic [2:0] cc, input logic z, n, v);
        case (cc)
            3'd0:    return !z;
            3'd1:    return z;
            3'd2:    return !z && !n;
            3'd3:    return n;
            3'd4:    return z || !n;
            3'd5:    return z || n;
            3'd6:    return v;
            default: return 1'b1;
        endcase
    endfunction

    // {aluSrc, regSrc, zEn, nvEn, memEnable, memWrite, regWrite, memToReg, hlt, pcs}
    function automatic logic [9:0] decodeOp(input logic [3:0] op);
        case (op)
            4'd0, 4'd1:       return 10'b0011001000;
            4'd2:             return 10'b0010001000;
            4'd3, 4'd7:       return 10'b0000001000;
            4'd4, 4'd5, 4'd6: return 10'b1010001000;
            4'd8:             return 10'b1000101100;
            4'd9:             return 10'b1000110100;
            4'd10, 4'd11:     return 10'b1100001000;
            4'd12, 4'd13:     return 10'b0000001000;
            4'd14:            return 10'b0000001001;
            default:          return 10'b0000000010;
        endcase
    endfunction

    task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic fillMemory(input int mode);      // Mode 0 without branches and mode 1 branch heavy
        logic [15:0] w;
        logic [3:0]  op;
        for (int i = 0; i < 64; i++) begin
            w  = 16'($random(seed));
            op = w[15:12];
            if (mode == 0 && i < 16) op = 4'(i);    // Sweep all opcodes first
            if (mode == 0 && (op == 4'd12 || op == 4'd13)) op = op - 4'd4;
            if (mode == 1 && w[0]) op = w[1] ? 4'd12 : 4'd13;
            if (op == 4'd15) op = 4'd14;            // HLT only in the halt test
            imem[i] = {op, w[11:0]};
        end
    endtask

    task automatic applyReset;
        rstN = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            check("imemAddr in reset", imemAddr, 16'h0);
            check("idValid in reset", {15'b0, idValid}, 16'h0);
            check("controls in reset", {2'b0, regWrite, updatePc, wenBht, wenBtb, hlt,
                  memEnable, memWrite, branch, aluSrc, zEn, nvEn, memToReg, pcs, regSrc}, 16'h0);
            check("aluOp in reset", {12'b0, aluOp}, 16'h0);
        end
        rstN        = 1'b1;
        mPc         = 16'h0;
        mIdValid    = 1'b0;
        redirectDue = 1'b0;
        for (int i = 0; i < 8; i++) begin
            mBht[i] = 2'd1;
            mBtb[i] = 16'h0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One cycle of stimulus, compare and model update
    //////////////////////////////////////////////////////////////////////
    task automatic runCycle;
        logic [3:0]  op;
        logic        isBr, aTaken, eUpd, eHlt, pTaken;
        logic [15:0] pcPlus2, aNext, target, pNext;
        logic [9:0]  eCtrl;
        logic [2:0]  fIdx, dIdx;
        zFlag = 1'($random(seed));                  // 1 ns after the edge
        nFlag = 1'($random(seed));
        vFlag = 1'($random(seed));
        brReg = 16'($random(seed));
        #4;
        op      = mIdInstr[15:12];
        isBr    = mIdValid && (op == 4'd12 || op == 4'd13);
        pcPlus2 = mIdPc + 16'd2;
        target  = (op == 4'd13) ? brReg
                : pcPlus2 + {{6{mIdInstr[8]}}, mIdInstr[8:0], 1'b0};
        aTaken  = (op == 4'd12 || op == 4'd13) && condHolds(mIdInstr[11:9], zFlag, nFlag, vFlag);
        aNext   = aTaken ? target : pcPlus2;
        eUpd    = isBr && (mIdPredNext != aNext);
        eCtrl   = mIdValid ? decodeOp(op) : 10'b0;
        eHlt    = eCtrl[1];
        fIdx    = mPc[3:1];
        dIdx    = mIdPc[3:1];
        pTaken  = mBht[fIdx][1];
        pNext   = pTaken ? mBtb[fIdx] : mPc + 16'd2;

        check("imemAddr", imemAddr, mPc);
        check("idValid", {15'b0, idValid}, {15'b0, mIdValid});
        if (mIdValid) check("idPc", idPc, mIdPc);
        check("controls", {6'b0, aluSrc, regSrc, zEn, nvEn, memEnable, memWrite, regWrite,
              memToReg, hlt, pcs}, {6'b0, eCtrl});
        check("aluOp", {12'b0, aluOp}, mIdValid ? {12'b0, op} : 16'h0);
        check("branch controls", {12'b0, branch, wenBht, wenBtb, updatePc},
              {12'b0, isBr, isBr, isBr && aTaken && eUpd, eUpd});
        if (redirectDue) check("redirect target", imemAddr, redirectAddr);

        redirectDue  = eUpd;
        redirectAddr = aNext;
        if (eUpd) redirects++;
        if (isBr) begin
            brDecodes++;
            if (aTaken && mBht[dIdx] != 2'd3) mBht[dIdx] = mBht[dIdx] + 2'd1;
            if (!aTaken && mBht[dIdx] != 2'd0) mBht[dIdx] = mBht[dIdx] - 2'd1;
            if (aTaken && eUpd) mBtb[dIdx] = aNext;
        end
        if (eUpd || !eHlt) begin
            mIdValid     = !eUpd;
            mIdInstr     = imem[mPc[6:1]];
            mIdPc        = mPc;
            mIdPredNext  = pNext;
        end
        if (eUpd) mPc = aNext;
        else if (!eHlt) mPc = pNext;
        @(posedge clk);
        #1;
    endtask

    task automatic reportTest(input string name);
        if (testErrors == 0) $display("Test %s: ok", name);
        else $display("Test %s: %0d errors", name, testErrors);
        testErrors = 0;
        redirects  = 0;
        brDecodes  = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int          waitCycles;
        logic [15:0] frozenPc;
        seed       = 32'hdeab;
        errors     = 0;
        testErrors = 0;
        redirects  = 0;
        brDecodes  = 0;
        timedOut   = 1'b0;
        rstN       = 1'b0;
        zFlag      = 1'b0;
        nFlag      = 1'b0;
        vFlag      = 1'b0;
        brReg      = 16'h0;
        fillMemory(0);
        #1;
        applyReset;
        runCycle;                                   // First cycle after reset
        reportTest("reset");

        for (int i = 0; i < 150; i++) runCycle;
        reportTest("decode");

        fillMemory(1);
        applyReset;
        for (int i = 0; i < 400; i++) runCycle;
        if (redirects == 0) begin
            $display("Branch test never saw a redirect");
            errors++;
            testErrors++;
        end
        reportTest("branch");

        for (int i = 0; i < 64; i++) imem[i] = 16'h0123;   // Plain ADD filler
        imem[1] = 16'hcffe;                         // Unconditional B back to word 0
        applyReset;
        waitCycles = 0;
        while (brDecodes < 3 && waitCycles < 50) begin
            runCycle;
            waitCycles++;
        end
        if (brDecodes < 3) begin
            $display("Loop branch was not decoded three times in time");
            timedOut = 1'b1;
            errors++;
            testErrors++;
        end
        if (redirects != 1) begin
            $display("Loop branch caused %0d redirects instead of one", redirects);
            errors++;
            testErrors++;
        end
        check("trained counter", {14'b0, FrontEnd_i.BranchPredictor_i.bht_i.entries[1]},
              {14'b0, mBht[1]});
        check("model counter", {14'b0, mBht[1]}, 16'h3);
        reportTest("training");

        fillMemory(0);
        imem[5] = 16'hf000;
        applyReset;
        waitCycles = 0;
        while (!hlt && waitCycles < 40) begin
            runCycle;
            waitCycles++;
        end
        if (!hlt) begin
            $display("HLT was never raised");
            timedOut = 1'b1;
            errors++;
            testErrors++;
        end
        frozenPc = imemAddr;
        for (int i = 0; i < 20; i++) begin
            runCycle;
            check("frozen imemAddr", imemAddr, frozenPc);
            check("regWrite in halt", {15'b0, regWrite}, 16'h0);
        end
        reportTest("halt");

        $display("Tests run 5, errors %0d", errors);
        if (errors == 0 && !timedOut) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/CpuPkg.sv
hdl/PredictTable.sv
hdl/BranchPredictor.sv
hdl/FetchUnit.sv
hdl/IfIdReg.sv
hdl/BranchResolver.sv
hdl/ControlUnit.sv
hdl/FrontEnd.sv
test/FrontEnd_checker.sv
test/FrontEndTb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module FrontEndTb -f sim.f

sim:
	verilator --binary --timing --assert --top-module FrontEndTb -f sim.f
	./obj_dir/VFrontEndTb | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
